/* Makefile */
# Verilator flow for the ant engine
VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= ant_engine_tb
RTL_TOP   ?= ant_engine
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only if the testbench printed the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
hdl/ant_pkg.sv
hdl/sprite_scan.sv
hdl/ant_motion.sv
hdl/instr_builder.sv
hdl/ant_sequencer.sv
hdl/ant_engine.sv
sim/ant_engine_tb.sv

/* sim/ant_input.txt */
# M addr data (hex) preloads a memory word, E addr data (hex) checks one
# U id dir steps ant id, D id draws it, B id draws it with extra start pulses
M 100 0020
M 101 0010
M 102 0005
M 104 0000
M 105 0030
M 106 00fe
M 108 009c
M 109 0075
M 10a 00ff
M 10c 0050
M 10d 0000
M 10e 0000
U 0 1
D 0
U 1 0
U 1 0
U 2 1
U 2 3
U 3 2
B 1
U 2 0
D 3
U 3 3
E 100 0021
E 102 0006
E 104 0000
E 106 00ff
E 108 009b
E 109 0075
E 10d 0001
E 10e 0002

/* sim/ant_engine_tb.sv */
`timescale 1ns/1ns

module ant_engine_tb;
    import ant_pkg::*;

    localparam int    SPRITE_W    = 4;
    localparam int    SPRITE_H    = 3;
    localparam int    SCREEN_W    = 160;
    localparam int    SCREEN_H    = 120;
    localparam int    CMD_TIMEOUT = 1000;
    localparam string INPUT_FILE  = "sim/ant_input.txt";

    logic       clock = 1'b0;
    logic       resetn;
    logic       start;
    logic       is_draw;
    addr_t      id;
    logic [1:0] rand_in;
    logic       finished;
    logic       start_dp;
    ant_instr_t instruction_dp;
    logic       finished_dp = 1'b0;
    result_t    result_dp = '0;

    // Memory behind the bus, and the memory the reference model predicts
    result_t    mem [4096];
    result_t    ref_mem [4096];
    ant_instr_t exp_q [$];

    int          error_count = 0;
    int          timeout_count = 0;
    int          tx_count = 0;
    int          cycle_no = 0;
    int          done_count = 0;
    int          total_tx = 0;
    int          last_done_cycle = -10;
    int          req_width = 0;
    int          delay_left = 0;
    bit          req_prev = 1'b0;
    bit          pending = 1'b0;
    ant_instr_t  active = '0;
    int unsigned lcg_state = 5;

    ant_engine #(
        .sprite_width  (SPRITE_W),
        .sprite_height (SPRITE_H),
        .screen_width  (SCREEN_W),
        .screen_height (SCREEN_H)
    ) dut0 (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .is_draw        (is_draw),
        .id             (id),
        .rand_in        (rand_in),
        .finished       (finished),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

    always #4 clock = ~clock;

    always @(posedge clock) cycle_no <= cycle_no + 1;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_instr(input string name, input ant_instr_t got, input ant_instr_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_word(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    function automatic addr_t field_addr(input addr_t cid, input int offset);
        return ANT_BASE + addr_t'(cid * ANT_RECORD_WORDS) + addr_t'(offset);
    endfunction

    function automatic ant_instr_t make_mem_word(input opcode_e op, input addr_t a,
                                                 input result_t wdata);
        ant_instr_t w;
        w            = '0;
        w.mem.wdata  = wdata;
        w.mem.addr   = a;
        w.mem.opcode = op;
        return w;
    endfunction

    function automatic ant_instr_t make_draw_word(input x_coord_t px, input y_coord_t py);
        ant_instr_t w;
        w             = '0;
        w.draw.plot   = 1'b1;
        w.draw.colour = COLOUR_ANT;
        w.draw.y      = py;
        w.draw.x      = px;
        w.draw.opcode = OPCODE_DRAW;
        return w;
    endfunction

    // Expected bus words of one command; an update also moves ref_mem forward
    task automatic predict_command(input bit draw, input addr_t cid, input logic [1:0] dir);
        addr_t    a_x;
        addr_t    a_y;
        addr_t    a_f;
        x_coord_t rx;
        y_coord_t ry;
        fitness_t rf;
        int       px;
        int       py;
        a_x = field_addr(cid, 0);
        a_y = field_addr(cid, 1);
        a_f = field_addr(cid, 2);
        rx  = x_coord_t'(ref_mem[a_x]);
        ry  = y_coord_t'(ref_mem[a_y]);
        rf  = fitness_t'(ref_mem[a_f]);
        exp_q.delete();
        exp_q.push_back(make_mem_word(OPCODE_MEMREAD, a_x, '0));
        exp_q.push_back(make_mem_word(OPCODE_MEMREAD, a_y, '0));
        if (draw) begin
            for (py = 0; py < SPRITE_H; py++) begin
                for (px = 0; px < SPRITE_W; px++) begin
                    exp_q.push_back(make_draw_word(rx - 8'd1 + x_coord_t'(px),
                                                   ry - 7'd1 + y_coord_t'(py)));
                end
            end
        end else begin
            exp_q.push_back(make_mem_word(OPCODE_MEMREAD, a_f, '0));
            // Blocked steps keep the whole sprite on screen
            case (dir)
                2'd0: if (rx > 0) rx = rx - 8'd1;
                2'd1: if (rx < x_coord_t'(SCREEN_W - SPRITE_W)) rx = rx + 8'd1;
                2'd2: if (ry > 0) ry = ry - 7'd1;
                default: if (ry < y_coord_t'(SCREEN_H - SPRITE_H)) ry = ry + 7'd1;
            endcase
            if (rf != 8'hff) begin
                rf = rf + 8'd1;
            end
            exp_q.push_back(make_mem_word(OPCODE_MEMWRITE, a_x, result_t'(rx)));
            exp_q.push_back(make_mem_word(OPCODE_MEMWRITE, a_y, result_t'(ry)));
            exp_q.push_back(make_mem_word(OPCODE_MEMWRITE, a_f, result_t'(rf)));
            ref_mem[a_x] = result_t'(rx);
            ref_mem[a_y] = result_t'(ry);
            ref_mem[a_f] = result_t'(rf);
        end
    endtask

    task automatic compare_record(input addr_t cid);
        addr_t a;
        int    f;
        for (f = 0; f < 3; f++) begin
            a = field_addr(cid, f);
            check_word($sformatf("mem[%h]", a), mem[a], ref_mem[a]);
        end
    endtask

    task automatic run_command(input logic [7:0] kind, input addr_t cid,
                               input logic [1:0] dir, output bit ok);
        int waited;
        bit exp_fin;
        predict_command(kind != "U", cid, dir);
        total_tx   = exp_q.size();
        done_count = 0;
        start      = 1'b1;
        is_draw    = (kind != "U");
        id         = cid;
        rand_in    = dir;
        @(posedge clock);
        #1;
        check_flag("finished", finished, 1'b0);
        start   = 1'b0;
        id      = '1;
        rand_in = ~dir;
        waited  = 0;
        while (finished !== 1'b1 && waited < CMD_TIMEOUT) begin
            @(posedge clock);
            #1;
            waited++;
            // Starts while busy must be ignored
            start   = (kind == "B") && (waited == 3 || waited == 20);
            exp_fin = (done_count == total_tx) && (last_done_cycle == cycle_no - 1);
            check_flag("finished", finished, exp_fin);
        end
        ok = (finished === 1'b1);
        if (!ok) begin
            $display("Timeout: command on ant %h did not finish in %0d cycles", cid, waited);
        end
    endtask

    // Datapath model: watches the two-cycle request and answers after a random delay
    always @(posedge clock) begin
        #1;
        finished_dp = 1'b0;
        if (resetn === 1'b1) begin
            if (start_dp && !req_prev) begin
                tx_count++;
                if (pending) begin
                    error_count++;
                    $display("New request at %0t before the previous one was answered", $time);
                end
                active    = instruction_dp;
                req_width = 1;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected transaction at %0t with word %h", $time, instruction_dp);
                end else begin
                    check_instr("instruction_dp", instruction_dp, exp_q.pop_front());
                end
            end else if (start_dp) begin
                req_width++;
                check_instr("instruction_dp", instruction_dp, active);
            end else if (req_prev) begin
                if (req_width != 2) begin
                    error_count++;
                    $display("start_dp was high for %0d cycles instead of two", req_width);
                end
                lcg_state  = lcg_next(lcg_state);
                delay_left = int'((lcg_state >> 16) % 4) + 1;
                pending    = 1'b1;
            end
            if (pending) begin
                if (delay_left <= 1) begin
                    pending     = 1'b0;
                    finished_dp = 1'b1;
                    if (active.mem.opcode == OPCODE_MEMREAD) begin
                        result_dp = mem[active.mem.addr];
                    end else if (active.mem.opcode == OPCODE_MEMWRITE) begin
                        mem[active.mem.addr] = active.mem.wdata;
                    end
                    done_count++;
                    last_done_cycle = cycle_no;
                end else begin
                    delay_left--;
                end
            end
            req_prev = start_dp;
        end
    end

    initial begin
        int          fd;
        int          n;
        int          i;
        string       line;
        logic [7:0]  kind;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        bit          ok;
        resetn  = 1'b0;
        start   = 1'b0;
        is_draw = 1'b0;
        id      = '0;
        rand_in = '0;
        ok      = 1'b1;
        for (i = 0; i < 4096; i++) begin
            mem[i]     = {4'hd, 12'(i)};
            ref_mem[i] = {4'hd, 12'(i)};
        end
        repeat (4) @(posedge clock);
        #1;
        resetn = 1'b1;
        check_flag("finished", finished, 1'b1);
        check_flag("start_dp", start_dp, 1'b0);
        check_instr("instruction_dp", instruction_dp, '0);

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the stimulus file %s", INPUT_FILE);
        end
        while (ok && fd != 0 && $fgets(line, fd) > 0) begin
            arg_b = '0;
            n     = $sscanf(line, "%c %h %h", kind, arg_a, arg_b);
            if (n < 1 || kind == "#" || kind == "\n") begin
                continue;
            end
            case (kind)
                "M": begin
                    mem[arg_a[11:0]]     = arg_b[15:0];
                    ref_mem[arg_a[11:0]] = arg_b[15:0];
                end
                "E": check_word($sformatf("mem[%h]", arg_a[11:0]), mem[arg_a[11:0]],
                                arg_b[15:0]);
                "U", "D", "B": begin
                    run_command(kind, addr_t'(arg_a), arg_b[1:0], ok);
                    if (!ok) begin
                        timeout_count++;
                    end else if (kind == "U") begin
                        compare_record(addr_t'(arg_a));
                    end
                end
                default: begin
                    error_count++;
                    $display("Unknown stimulus line: %s", line);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Quiet tail so a stray request still shows up
        repeat (10) @(posedge clock);
        #1;
        $display("Checks done: %0d errors, %0d timeouts, %0d bus transactions",
                 error_count, timeout_count, tx_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* hdl/ant_engine.sv */
`timescale 1ns/1ns

module ant_engine #(
    parameter int sprite_width  = 4,
    parameter int sprite_height = 3,
    parameter int screen_width  = 160,
    parameter int screen_height = 120
) (
    input  logic                clock,
    input  logic                resetn,
    input  logic                start,
    input  logic                is_draw,
    input  ant_pkg::addr_t      id,
    input  logic [1:0]          rand_in,
    output logic                finished,
    output logic                start_dp,
    output ant_pkg::ant_instr_t instruction_dp,
    input  logic                finished_dp,
    input  ant_pkg::result_t    result_dp
);
    import ant_pkg::*;

    logic       build;
    bus_step_e  step;
    ant_field_e field;
    logic       load;
    logic       advance;
    logic [1:0] rand_dir;
    logic       scan_clear;
    logic       scan_next;
    logic       last;
    x_coord_t   x;
    y_coord_t   y;
    fitness_t   fitness;
    x_coord_t   dx;
    y_coord_t   dy;

    ant_sequencer seq0 (
        .clock       (clock),
        .resetn      (resetn),
        .start       (start),
        .is_draw     (is_draw),
        .rand_in     (rand_in),
        .finished    (finished),
        .start_dp    (start_dp),
        .finished_dp (finished_dp),
        .build       (build),
        .step        (step),
        .field       (field),
        .load        (load),
        .advance     (advance),
        .rand_dir    (rand_dir),
        .scan_clear  (scan_clear),
        .scan_next   (scan_next),
        .last        (last)
    );

    ant_motion #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .sprite_width  (sprite_width),
        .sprite_height (sprite_height)
    ) motion0 (
        .clock     (clock),
        .resetn    (resetn),
        .load      (load),
        .field     (field),
        .result_dp (result_dp),
        .advance   (advance),
        .rand_dir  (rand_dir),
        .x         (x),
        .y         (y),
        .fitness   (fitness)
    );

    sprite_scan #(
        .sprite_width  (sprite_width),
        .sprite_height (sprite_height)
    ) scan0 (
        .clock  (clock),
        .resetn (resetn),
        .clear  (scan_clear),
        .next   (scan_next),
        .dx     (dx),
        .dy     (dy),
        .last   (last)
    );

    instr_builder builder0 (
        .clock          (clock),
        .resetn         (resetn),
        .build          (build),
        .step           (step),
        .field          (field),
        .id             (id),
        .x              (x),
        .y              (y),
        .fitness        (fitness),
        .dx             (dx),
        .dy             (dy),
        .instruction_dp (instruction_dp)
    );

endmodule

/* hdl/ant_sequencer.sv */
`timescale 1ns/1ns

module ant_sequencer (
    input  logic                clock,
    input  logic                resetn,
    input  logic                start,
    input  logic                is_draw,
    input  logic [1:0]          rand_in,
    output logic                finished,
    output logic                start_dp,
    input  logic                finished_dp,
    output logic                build,
    output ant_pkg::bus_step_e  step,
    output ant_pkg::ant_field_e field,
    output logic                load,
    output logic                advance,
    output logic [1:0]          rand_dir,
    output logic                scan_clear,
    output logic                scan_next,
    input  logic                last
);
    import ant_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_ISSUE, ST_HOLD, ST_WAIT, ST_MOVE} state_e;

    state_e     state;
    logic       draw_mode;
    bus_step_e  cur_step;
    ant_field_e cur_field;
    logic       accept;
    logic       done;
    logic       read_last;
    logic       cmd_end;

    assign accept = (state == ST_IDLE) && start && finished;
    assign done   = (state == ST_WAIT) && finished_dp;

    // Final read is y for a draw and fitness for an update
    assign read_last = draw_mode ? (cur_field == FIELD_Y) : (cur_field == FIELD_FITNESS);

    // Request is held for two cycles
    assign start_dp = (state == ST_ISSUE) || (state == ST_HOLD);

    // Field of the transfer in flight, the builder addresses the one after it
    assign field      = cur_field;
    assign load       = done && (cur_step == STEP_READ);
    assign advance    = (state == ST_MOVE);
    assign scan_clear = accept;
    assign scan_next  = done && (cur_step == STEP_DRAW);

    // Choose the next bus step, built in the cycle before it is issued
    always_comb begin
        build   = 1'b0;
        step    = cur_step;
        cmd_end = 1'b0;
        if (accept) begin
            build = 1'b1;
            step  = STEP_READ;
        end else if (state == ST_MOVE) begin
            build = 1'b1;
            step  = STEP_WRITE;
        end else if (done) begin
            case (cur_step)
                STEP_READ: begin
                    if (!read_last) begin
                        build = 1'b1;
                        step  = STEP_READ;
                    end else if (draw_mode) begin
                        build = 1'b1;
                        step  = STEP_DRAW;
                    end
                end
                STEP_WRITE: begin
                    if (cur_field == FIELD_FITNESS) begin
                        cmd_end = 1'b1;
                    end else begin
                        build = 1'b1;
                    end
                end
                default: begin
                    if (last) begin
                        cmd_end = 1'b1;
                    end else begin
                        build = 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            finished  <= 1'b1;
            draw_mode <= 1'b0;
            rand_dir  <= 2'd0;
            cur_step  <= STEP_READ;
            cur_field <= FIELD_FITNESS;
        end else begin
            if (accept) begin
                finished  <= 1'b0;
                draw_mode <= is_draw;
                rand_dir  <= rand_in;
            end
            if (build) begin
                cur_step <= step;
                if (step != STEP_DRAW) begin
                    cur_field <= next_field(cur_field);
                end
            end
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: state <= ST_HOLD;
                ST_HOLD:  state <= ST_WAIT;
                ST_WAIT: begin
                    if (build) begin
                        state <= ST_ISSUE;
                    end else if (cmd_end) begin
                        state     <= ST_IDLE;
                        finished  <= 1'b1;
                        cur_field <= FIELD_FITNESS;
                    end else if (done) begin
                        // Fitness is in, one cycle to step the ant
                        state <= ST_MOVE;
                    end
                end
                default: state <= ST_ISSUE;
            endcase
        end
    end

endmodule

/* hdl/instr_builder.sv */
`timescale 1ns/1ns

module instr_builder (
    input  logic                clock,
    input  logic                resetn,
    input  logic                build,
    input  ant_pkg::bus_step_e  step,
    input  ant_pkg::ant_field_e field,
    input  ant_pkg::addr_t      id,
    input  ant_pkg::x_coord_t   x,
    input  ant_pkg::y_coord_t   y,
    input  ant_pkg::fitness_t   fitness,
    input  ant_pkg::x_coord_t   dx,
    input  ant_pkg::y_coord_t   dy,
    output ant_pkg::ant_instr_t instruction_dp
);
    import ant_pkg::*;

    ant_field_e target;
    logic       open_cmd;
    addr_t      rec_id;
    addr_t      id_q;
    addr_t      addr;
    result_t    wdata;
    ant_instr_t word;

    assign target = next_field(field);

    // Read of x opens every command; later steps reuse the held id
    assign open_cmd = (step == STEP_READ) && (target == FIELD_X);
    assign rec_id   = open_cmd ? id : id_q;
    assign addr     = ANT_BASE + addr_t'(rec_id * ANT_RECORD_WORDS) + addr_t'(target);

    always_comb begin
        case (target)
            FIELD_X: wdata = result_t'(x);
            FIELD_Y: wdata = result_t'(y);
            default: wdata = result_t'(fitness);
        endcase
    end

    always_comb begin
        word = '0;
        if (step == STEP_DRAW) begin
            // Sprite origin sits one pixel up and left of the ant
            word.draw.plot   = 1'b1;
            word.draw.colour = COLOUR_ANT;
            word.draw.y      = y - 7'd1 + dy;
            word.draw.x      = x - 8'd1 + dx;
            word.draw.opcode = OPCODE_DRAW;
        end else if (step == STEP_WRITE) begin
            word.mem.wdata  = wdata;
            word.mem.addr   = addr;
            word.mem.opcode = OPCODE_MEMWRITE;
        end else begin
            word.mem.addr   = addr;
            word.mem.opcode = OPCODE_MEMREAD;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            instruction_dp <= '0;
        end else if (build) begin
            instruction_dp <= word;
        end
    end

    always_ff @(posedge clock) begin
        if (build) begin
            id_q <= rec_id;
        end
    end

endmodule

/* hdl/ant_motion.sv */
`timescale 1ns/1ns

module ant_motion #(
    parameter int screen_width  = 160,
    parameter int screen_height = 120,
    parameter int sprite_width  = 4,
    parameter int sprite_height = 3
) (
    input  logic                clock,
    input  logic                resetn,
    input  logic                load,
    input  ant_pkg::ant_field_e field,
    input  ant_pkg::result_t    result_dp,
    input  logic                advance,
    input  logic [1:0]          rand_dir,
    output ant_pkg::x_coord_t   x,
    output ant_pkg::y_coord_t   y,
    output ant_pkg::fitness_t   fitness
);
    import ant_pkg::*;

    // Largest origin that keeps the whole sprite on screen
    localparam x_coord_t X_MAX = x_coord_t'(screen_width - sprite_width);
    localparam y_coord_t Y_MAX = y_coord_t'(screen_height - sprite_height);

    x_coord_t x_q;
    x_coord_t x_n;
    y_coord_t y_q;
    y_coord_t y_n;
    fitness_t fit_q;
    fitness_t fit_n;

    always_comb begin
        x_n   = x_q;
        y_n   = y_q;
        fit_n = fit_q;
        if (load) begin
            case (field)
                FIELD_X: x_n = x_coord_t'(result_dp);
                FIELD_Y: y_n = y_coord_t'(result_dp);
                default: fit_n = fitness_t'(result_dp);
            endcase
        end
        if (advance) begin
            // 0 left, 1 right, 2 up, 3 down; blocked steps leave the ant in place
            case (rand_dir)
                2'd0: if (x_q != '0) x_n = x_q - 8'd1;
                2'd1: if (x_q < X_MAX) x_n = x_q + 8'd1;
                2'd2: if (y_q != '0) y_n = y_q - 7'd1;
                default: if (y_q < Y_MAX) y_n = y_q + 7'd1;
            endcase
            if (fit_q != '1) begin
                fit_n = fit_q + 8'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            x_q   <= '0;
            y_q   <= '0;
            fit_q <= '0;
        end else begin
            x_q   <= x_n;
            y_q   <= y_n;
            fit_q <= fit_n;
        end
    end

    // Outputs lead the registers so a word built this cycle sees the new value
    assign x       = x_n;
    assign y       = y_n;
    assign fitness = fit_n;

endmodule

/* hdl/sprite_scan.sv */
`timescale 1ns/1ns

module sprite_scan #(
    parameter int sprite_width  = 4,
    parameter int sprite_height = 3
) (
    input  logic              clock,
    input  logic              resetn,
    input  logic              clear,
    input  logic              next,
    output ant_pkg::x_coord_t dx,
    output ant_pkg::y_coord_t dy,
    output logic              last
);
    import ant_pkg::*;

    localparam x_coord_t DX_LAST = x_coord_t'(sprite_width - 1);
    localparam y_coord_t DY_LAST = y_coord_t'(sprite_height - 1);

    x_coord_t dx_q;
    x_coord_t dx_n;
    y_coord_t dy_q;
    y_coord_t dy_n;

    // Raster order, x fastest, wrapping to the origin after the last pixel
    always_comb begin
        dx_n = dx_q;
        dy_n = dy_q;
        if (clear) begin
            dx_n = '0;
            dy_n = '0;
        end else if (next) begin
            if (dx_q == DX_LAST) begin
                dx_n = '0;
                dy_n = (dy_q == DY_LAST) ? '0 : dy_q + 7'd1;
            end else begin
                dx_n = dx_q + 8'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            dx_q <= '0;
            dy_q <= '0;
        end else begin
            dx_q <= dx_n;
            dy_q <= dy_n;
        end
    end

    assign dx   = dx_n;
    assign dy   = dy_n;
    assign last = (dx_q == DX_LAST) && (dy_q == DY_LAST);

endmodule

/* hdl/ant_pkg.sv */
package ant_pkg;

    typedef logic [11:0] addr_t;
    typedef logic [7:0]  x_coord_t;
    typedef logic [6:0]  y_coord_t;
    typedef logic [7:0]  fitness_t;
    typedef logic [2:0]  colour_t;
    typedef logic [15:0] result_t;

    typedef enum logic [1:0] {
        OPCODE_MEMREAD  = 2'd0,
        OPCODE_MEMWRITE = 2'd1,
        OPCODE_DRAW     = 2'd2
    } opcode_e;

    // Encodings double as the word offset inside an ant record
    typedef enum logic [1:0] {
        FIELD_X       = 2'd0,
        FIELD_Y       = 2'd1,
        FIELD_FITNESS = 2'd2
    } ant_field_e;

    typedef enum logic [1:0] {
        STEP_READ  = 2'd0,
        STEP_WRITE = 2'd1,
        STEP_DRAW  = 2'd2
    } bus_step_e;

    // Ant table layout
    localparam addr_t   ANT_BASE         = 12'h100;
    localparam int      ANT_RECORD_WORDS = 4;
    localparam colour_t COLOUR_ANT       = 3'b100;

    typedef struct packed {
        result_t wdata;
        addr_t   addr;
        opcode_e opcode;
    } mem_instr_t;

    typedef struct packed {
        logic [8:0] pad;
        logic       plot;
        colour_t    colour;
        y_coord_t   y;
        x_coord_t   x;
        opcode_e    opcode;
    } draw_instr_t;

    // One 30-bit bus word, opcode always in the low two bits
    typedef union packed {
        mem_instr_t  mem;
        draw_instr_t draw;
    } ant_instr_t;

    // Fields are walked as a ring: x, y, fitness, then x again
    function automatic ant_field_e next_field(ant_field_e f);
        case (f)
            FIELD_X: return FIELD_Y;
            FIELD_Y: return FIELD_FITNESS;
            default: return FIELD_X;
        endcase
    endfunction

endpackage
